// ==== project.f ====
logic/rx_correlator_pkg.sv
logic/rx_chip_adder.sv
logic/rx_sequence_feeder.sv
logic/rx_sequence_accumulator.sv
logic/rx_correlator.sv
verif/rx_correlator_checker.sv
verif/tb_rx_correlator.sv

// ==== Makefile ====
# Verilator build and run of the rx correlator testbench

VERILATOR ?= verilator
TOP       ?= tb_rx_correlator
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list the targets and variables"
	@echo "variables (override on the command line):"
	@echo "  VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
	  echo "simulation result: PASS"; \
	else \
	  echo "simulation result: FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_rx_correlator.sv ====
/* rx correlator testbench
   drives chips and symbol triggers through the correlator while the checker compares */
`timescale 1ns/1ps
`default_nettype none

module tb_rx_correlator;

  localparam int          CLK_PERIOD     = 8;
  localparam int          RESET_CYCLES   = 10;
  localparam int unsigned RAND_SEED      = 32'h291b_f1f4;
  localparam int          N_RAND_SYMBOLS = 12;
  localparam int          MAX_SYM_LEN    = 40;
  localparam int          N_GAP_SYMBOLS  = 6;
  localparam int          MAX_GAP_CHIPS  = 8;
  localparam int          MAX_GAP        = 3;
  localparam int          STROBE_WAIT    = 12;  // cycles allowed from trigger to strobe
  localparam int          N_CLOSES       = 6;
  localparam int          WATCHDOG_CYCLES = RESET_CYCLES + 40
                                          + N_RAND_SYMBOLS * MAX_SYM_LEN
                                          + N_GAP_SYMBOLS * (MAX_GAP_CHIPS * (MAX_GAP + 1) + 2)
                                          + N_CLOSES * (STROBE_WAIT + 3)
                                          + 500;  // margin

  logic                           crx_clk;
  logic                           rrx_rst;
  logic                           en;
  logic                           symbol_trig;
  logic                           chip_valid;
  rx_correlator_pkg::sample_bus_t samples;
  rx_correlator_pkg::corr_bus_t   results;
  logic                           result_valid;

  int   check_count;   // from the checker
  int   error_count;
  int   tb_checks;
  int   tb_errors;
  int   prev_checks;
  int   prev_errors;
  int   test_num;
  int   sym_len;
  int   gap;
  logic early_strobe;

  rx_correlator dut0 (
    .crx_clk      (crx_clk),
    .rrx_rst      (rrx_rst),
    .en           (en),
    .symbol_trig  (symbol_trig),
    .chip_valid   (chip_valid),
    .samples      (samples),
    .results      (results),
    .result_valid (result_valid)
  );

  rx_correlator_checker checker0 (
    .crx_clk      (crx_clk),
    .rrx_rst      (rrx_rst),
    .en           (en),
    .symbol_trig  (symbol_trig),
    .chip_valid   (chip_valid),
    .samples      (samples),
    .results      (results),
    .result_valid (result_valid),
    .check_count  (check_count),
    .error_count  (error_count)
  );

  initial begin
    crx_clk = 1'b0;
    forever #(CLK_PERIOD / 2) crx_clk = ~crx_clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, test sequence did not finish", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  // applies one cycle of inputs on the falling edge
  task automatic drive_cycle(input logic trig, input logic valid,
                             input rx_correlator_pkg::sample_bus_t samp);
    @(negedge crx_clk);
    symbol_trig = trig;
    chip_valid  = valid;
    samples     = samp;
  endtask

  task automatic idle_cycles(input int n);
    for (int c = 0; c < n; c++) begin
      drive_cycle(1'b0, 1'b0, '0);
    end
  endtask

  function automatic rx_correlator_pkg::sample_bus_t random_chip();
    rx_correlator_pkg::sample_bus_t bus;
    bus = '0;
    for (int i = 0; i < rx_correlator_pkg::N_SAMPLES; i++) begin
      bus[i*rx_correlator_pkg::SAMPLE_W +: rx_correlator_pkg::SAMPLE_W] =
        rx_correlator_pkg::sample_t'($urandom);  // full signed range
    end
    return bus;
  endfunction

  function automatic rx_correlator_pkg::sample_bus_t ones_chip();
    rx_correlator_pkg::sample_bus_t bus;
    bus = '0;
    for (int i = 0; i < rx_correlator_pkg::N_SAMPLES; i++) begin
      bus[i*rx_correlator_pkg::SAMPLE_W +: rx_correlator_pkg::SAMPLE_W] =
        rx_correlator_pkg::sample_t'(1);
    end
    return bus;
  endfunction

  // trigger alone, then wait for the strobe of the symbol it closes
  task automatic close_symbol();
    logic seen;
    seen = 1'b0;
    drive_cycle(1'b1, 1'b0, '0);
    for (int c = 0; c < STROBE_WAIT && !seen; c++) begin
      drive_cycle(1'b0, 1'b0, '0);
      if (result_valid) seen = 1'b1;
    end
    tb_checks++;
    if (!seen) begin
      tb_errors++;
      $display("no result strobe within %0d cycles of the symbol trigger", STROBE_WAIT);
    end
  endtask

  // one chip of all ones gives +20 or -20 with the seed bit as sign
  task automatic check_unit_chip();
    rx_correlator_pkg::corr_t got;
    rx_correlator_pkg::corr_t want;
    for (int i = 0; i < rx_correlator_pkg::N_SEQ; i++) begin
      got  = results[i*rx_correlator_pkg::CORR_W +: rx_correlator_pkg::CORR_W];
      want = rx_correlator_pkg::SEQ_SEED[i] ? rx_correlator_pkg::corr_t'(20)
                                            : rx_correlator_pkg::corr_t'(-20);
      tb_checks++;
      if (got !== want) begin
        tb_errors++;
        $display("ERR results[%0d] got %h expected %h", i, got, want);
      end
    end
  endtask

  task automatic finish_test(input string name);
    int checks;
    int errors;
    idle_cycles(2);  // let the checker finish the last compare
    checks = check_count + tb_checks - prev_checks;
    errors = error_count + tb_errors - prev_errors;
    $display("test %0d %s: %0d checks, %0d errors, %s", test_num, name, checks, errors,
             (errors == 0) ? "ok" : "mismatch");
    prev_checks = check_count + tb_checks;
    prev_errors = error_count + tb_errors;
    test_num++;
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    rrx_rst      = 1'b1;
    en           = 1'b1;
    symbol_trig  = 1'b0;
    chip_valid   = 1'b0;
    samples      = '0;
    tb_checks    = 0;
    tb_errors    = 0;
    prev_checks  = 0;
    prev_errors  = 0;
    test_num     = 1;
    early_strobe = 1'b0;
    repeat (RESET_CYCLES) @(negedge crx_clk);
    rrx_rst = 1'b0;

    for (int c = 0; c < 20; c++) begin
      drive_cycle(1'b0, 1'b0, '0);
      if (result_valid) early_strobe = 1'b1;
    end
    tb_checks++;
    if (early_strobe) begin
      tb_errors++;
      $display("result strobe seen after reset before any symbol trigger");
    end
    close_symbol();  // nothing accumulated yet
    finish_test("empty first symbol");

    drive_cycle(1'b0, 1'b1, ones_chip());
    close_symbol();
    check_unit_chip();
    finish_test("single chip of ones");

    for (int s = 0; s < N_RAND_SYMBOLS; s++) begin
      sym_len = $urandom_range(MAX_SYM_LEN, 1);
      for (int j = 0; j < sym_len; j++) begin
        drive_cycle(j == 0, 1'b1, random_chip());  // back to back
      end
    end
    close_symbol();
    finish_test("random symbols back to back");

    for (int s = 0; s < N_GAP_SYMBOLS; s++) begin
      drive_cycle(1'b1, s % 2 == 0, random_chip());  // even symbols start with a chip
      if (s == 2) drive_cycle(1'b1, 1'b0, '0);       // second trigger right behind
      sym_len = $urandom_range(MAX_GAP_CHIPS, 1);
      for (int j = 0; j < sym_len; j++) begin
        gap = $urandom_range(MAX_GAP, 0);
        idle_cycles(gap);
        drive_cycle(1'b0, 1'b1, random_chip());
      end
    end
    close_symbol();
    finish_test("trigger with chip and gapped symbols");

    for (int j = 0; j < 5; j++) begin
      drive_cycle(1'b0, 1'b1, random_chip());
    end
    drive_cycle(1'b0, 1'b0, '0);
    en = 1'b0;  // drops the chips still in flight
    idle_cycles(4);
    en = 1'b1;
    idle_cycles(2);
    for (int j = 0; j < 3; j++) begin
      drive_cycle(1'b0, 1'b1, random_chip());
    end
    close_symbol();
    finish_test("enable drop mid symbol");

    idle_cycles(4);
    $display("total: %0d checks, %0d errors", check_count + tb_checks, error_count + tb_errors);
    if (error_count + tb_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/rx_correlator_checker.sv ====
/* rx correlator checker
   records accepted chips, models the 16 expected correlations and compares every result strobe */
`timescale 1ns/1ps
`default_nettype none

module rx_correlator_checker (
  input  wire                                 crx_clk,
  input  wire                                 rrx_rst,
  input  wire                                 en,
  input  wire                                 symbol_trig,
  input  wire                                 chip_valid,
  input  wire rx_correlator_pkg::sample_bus_t samples,
  input  wire rx_correlator_pkg::corr_bus_t   results,
  input  wire                                 result_valid,
  output int                                  check_count,
  output int                                  error_count
);

  localparam int RESULT_LATENCY = 6;  // falling edges from trigger edge to strobe

  longint                       chip_sums [$];  // chips of the open symbol
  rx_correlator_pkg::corr_bus_t expected  [$];  // closed symbols awaiting their strobe
  int                           age       [$];  // falling edges seen per closed symbol
  rx_correlator_pkg::corr_bus_t held;           // last strobed results

  // exact sum of the 20 signed samples of one chip
  function automatic longint chip_total(input rx_correlator_pkg::sample_bus_t bus);
    longint                     total;
    rx_correlator_pkg::sample_t s;
    total = 0;
    for (int i = 0; i < rx_correlator_pkg::N_SAMPLES; i++) begin
      s     = bus[i*rx_correlator_pkg::SAMPLE_W +: rx_correlator_pkg::SAMPLE_W];
      total = total + longint'(s);
    end
    return total;
  endfunction

  // expected correlations with chip j signed by the LFSR state after j steps from the seed
  function automatic rx_correlator_pkg::corr_bus_t expected_corr(input longint sums[$]);
    longint                        acc [rx_correlator_pkg::N_SEQ];
    rx_correlator_pkg::seq_bits_t  state;
    rx_correlator_pkg::corr_bus_t  packed_res;
    for (int i = 0; i < rx_correlator_pkg::N_SEQ; i++) begin
      acc[i] = 0;
    end
    state = rx_correlator_pkg::SEQ_SEED;
    foreach (sums[j]) begin
      for (int i = 0; i < rx_correlator_pkg::N_SEQ; i++) begin
        if (state[i]) acc[i] = acc[i] + sums[j];  // 1 adds
        else          acc[i] = acc[i] - sums[j];
      end
      state = {state[rx_correlator_pkg::N_SEQ-2:0], ^(state & rx_correlator_pkg::SEQ_TAPS)};
    end
    for (int i = 0; i < rx_correlator_pkg::N_SEQ; i++) begin
      packed_res[i*rx_correlator_pkg::CORR_W +: rx_correlator_pkg::CORR_W] =
        acc[i][rx_correlator_pkg::CORR_W-1:0];
    end
    return packed_res;
  endfunction

  task automatic compare_results(input rx_correlator_pkg::corr_bus_t exp_bus);
    rx_correlator_pkg::corr_t got;
    rx_correlator_pkg::corr_t want;
    for (int i = 0; i < rx_correlator_pkg::N_SEQ; i++) begin
      got  = results[i*rx_correlator_pkg::CORR_W +: rx_correlator_pkg::CORR_W];
      want = exp_bus[i*rx_correlator_pkg::CORR_W +: rx_correlator_pkg::CORR_W];
      check_count++;
      if (got !== want) begin
        error_count++;
        $display("ERR results[%0d] got %h expected %h", i, got, want);
      end
    end
  endtask

  initial begin
    check_count = 0;
    error_count = 0;
    held        = '0;
  end

  // records each accepted chip at the rising edge where inputs are stable
  always @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      chip_sums.delete();  // pipeline contents are lost too
      expected.delete();
      age.delete();
    end else begin
      if (symbol_trig) begin
        expected.push_back(expected_corr(chip_sums));
        age.push_back(0);
        chip_sums.delete();
      end
      if (chip_valid) chip_sums.push_back(chip_total(samples));  // joins the new symbol
    end
  end

  // outputs are read half a cycle after they change
  always @(negedge crx_clk) begin
    for (int k = 0; k < age.size(); k++) begin
      age[k] = age[k] + 1;
    end
    if (result_valid) begin
      if (expected.size() == 0) begin
        error_count++;
        $display("result strobe at %0t ns with no symbol trigger pending", $time);
      end else begin
        if (age[0] != RESULT_LATENCY) begin
          error_count++;
          $display("result strobe came %0d cycles after its symbol trigger instead of %0d",
                   age[0], RESULT_LATENCY);
        end
        compare_results(expected[0]);
        expected.delete(0);
        age.delete(0);
      end
      held = results;
    end else begin
      check_count++;
      if (results !== held) begin  // results hold between strobes
        error_count++;
        $display("ERR results got %h expected %h between strobes", results, held);
        held = results;
      end
    end
    if (age.size() > 0 && age[0] >= RESULT_LATENCY) begin
      error_count++;
      $display("result strobe missing %0d cycles after a symbol trigger", RESULT_LATENCY);
      expected.delete(0);
      age.delete(0);
    end
  end

endmodule

`default_nettype wire

// ==== logic/rx_correlator.sv ====
/* rx correlator top
   chip adder tree feeding 16 sign-weighted accumulators driven by the sequence LFSR */
`timescale 1ns/1ps
`default_nettype none

module rx_correlator (
  input  wire                                 crx_clk,
  input  wire                                 rrx_rst,
  input  wire                                 en,
  input  wire                                 symbol_trig,
  input  wire                                 chip_valid,
  input  wire rx_correlator_pkg::sample_bus_t samples,
  output rx_correlator_pkg::corr_bus_t        results,
  output logic                                result_valid
);

  // adder tree outputs, five cycles behind the inputs
  rx_correlator_pkg::chip_sum_t chip_sum;
  logic                         sum_valid;
  logic                         sym_mark;

  // signs for the chip now at the tree output
  rx_correlator_pkg::seq_bits_t seq_bits;

  rx_chip_adder u_chip_adder (
    .crx_clk     (crx_clk),
    .rrx_rst     (rrx_rst),
    .en          (en),
    .symbol_trig (symbol_trig),
    .chip_valid  (chip_valid),
    .samples     (samples),
    .chip_sum    (chip_sum),
    .sum_valid   (sum_valid),
    .sym_mark    (sym_mark)
  );

  rx_sequence_feeder u_sequence_feeder (
    .crx_clk     (crx_clk),
    .rrx_rst     (rrx_rst),
    .en          (en),
    .sum_valid   (sum_valid),
    .sym_mark    (sym_mark),
    .seq_bits    (seq_bits)
  );

  rx_sequence_accumulator u_sequence_accumulator (
    .crx_clk      (crx_clk),
    .rrx_rst      (rrx_rst),
    .en           (en),
    .chip_sum     (chip_sum),
    .sum_valid    (sum_valid),
    .sym_mark     (sym_mark),
    .seq_bits     (seq_bits),
    .results      (results),
    .result_valid (result_valid)
  );

endmodule

`default_nettype wire

// ==== logic/rx_sequence_accumulator.sv ====
/* rx sequence accumulator
   16 signed running correlations, latched out with a one-cycle strobe at each symbol start */
`timescale 1ns/1ps
`default_nettype none

module rx_sequence_accumulator (
  input  wire                               crx_clk,
  input  wire                               rrx_rst,
  input  wire                               en,
  input  wire rx_correlator_pkg::chip_sum_t chip_sum,
  input  wire                               sum_valid,
  input  wire                               sym_mark,
  input  wire rx_correlator_pkg::seq_bits_t seq_bits,
  output rx_correlator_pkg::corr_bus_t      results,
  output logic                              result_valid
);

  rx_correlator_pkg::corr_t acc_q    [rx_correlator_pkg::N_SEQ];
  rx_correlator_pkg::corr_t acc_base [rx_correlator_pkg::N_SEQ];  // start value this cycle
  rx_correlator_pkg::corr_t term     [rx_correlator_pkg::N_SEQ];  // signed chip contribution
  rx_correlator_pkg::corr_t chip_ext;

  assign chip_ext = rx_correlator_pkg::corr_t'(chip_sum);

  always_comb begin
    for (int i = 0; i < rx_correlator_pkg::N_SEQ; i++) begin
      term[i]     = seq_bits[i] ? chip_ext : -chip_ext;
      acc_base[i] = sym_mark ? '0 : acc_q[i];   // new symbol starts from zero
    end
  end

  // running correlations
  always_ff @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      for (int i = 0; i < rx_correlator_pkg::N_SEQ; i++) begin
        acc_q[i] <= '0;
      end
    end else if (sum_valid) begin
      for (int i = 0; i < rx_correlator_pkg::N_SEQ; i++) begin
        acc_q[i] <= acc_base[i] + term[i];
      end
    end else if (sym_mark) begin
      for (int i = 0; i < rx_correlator_pkg::N_SEQ; i++) begin
        acc_q[i] <= '0;
      end
    end
  end

  // finished totals, held until the next boundary and kept across en low
  always_ff @(posedge crx_clk) begin
    if (rrx_rst) begin
      results <= '0;
    end else if (en && sym_mark) begin
      for (int i = 0; i < rx_correlator_pkg::N_SEQ; i++) begin
        results[i*rx_correlator_pkg::CORR_W +: rx_correlator_pkg::CORR_W] <= acc_q[i];
      end
    end
  end

  always_ff @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= sym_mark;  // same edge as the latch
    end
  end

endmodule

`default_nettype wire

// ==== logic/rx_sequence_feeder.sv ====
/* rx sequence feeder
   16-bit fibonacci LFSR giving the sign of each sequence for the chip leaving the tree */
`timescale 1ns/1ps
`default_nettype none

module rx_sequence_feeder (
  input  wire                          crx_clk,
  input  wire                          rrx_rst,
  input  wire                          en,
  input  wire                          sum_valid,
  input  wire                          sym_mark,
  output rx_correlator_pkg::seq_bits_t seq_bits
);

  rx_correlator_pkg::seq_bits_t lfsr_q;
  rx_correlator_pkg::seq_bits_t base;     // state used by the current chip
  rx_correlator_pkg::seq_bits_t stepped;  // base advanced by one chip

  // a symbol boundary restarts the sequence at the seed right away,
  // so a chip arriving with the mark already uses chip 0 signs
  assign base    = sym_mark ? rx_correlator_pkg::SEQ_SEED : lfsr_q;
  assign stepped = {base[rx_correlator_pkg::N_SEQ-2:0],
                    ^(base & rx_correlator_pkg::SEQ_TAPS)};

  // bit i is the sign for sequence i
  assign seq_bits = base;

  always_ff @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      lfsr_q <= rx_correlator_pkg::SEQ_SEED;
    end else if (sum_valid) begin
      lfsr_q <= stepped;                       // one step per accumulated chip
    end else if (sym_mark) begin
      lfsr_q <= rx_correlator_pkg::SEQ_SEED;   // empty boundary cycle
    end
  end

endmodule

`default_nettype wire

// ==== logic/rx_chip_adder.sv ====
/* rx chip adder
   captures 20 samples per chip and reduces them in a 4-level pipelined tree, marks ride along */
`timescale 1ns/1ps
`default_nettype none

module rx_chip_adder (
  input  wire                                 crx_clk,
  input  wire                                 rrx_rst,
  input  wire                                 en,
  input  wire                                 symbol_trig,
  input  wire                                 chip_valid,
  input  wire rx_correlator_pkg::sample_bus_t samples,
  output rx_correlator_pkg::chip_sum_t        chip_sum,
  output logic                                sum_valid,
  output logic                                sym_mark
);

  rx_correlator_pkg::sample_t   samp_q  [rx_correlator_pkg::N_SAMPLES];  // capture stage
  rx_correlator_pkg::chip_sum_t grp_sum [rx_correlator_pkg::N_GROUPS];   // comb, groups of 4
  rx_correlator_pkg::chip_sum_t part1   [rx_correlator_pkg::N_GROUPS];   // five partial sums
  rx_correlator_pkg::chip_sum_t part2   [3];
  rx_correlator_pkg::chip_sum_t part3   [2];

  // marks for capture, part1, part2 and part3, the output regs are the fifth stage
  logic [3:0] valid_pipe;
  logic [3:0] mark_pipe;

  // chip valid and symbol marks travel with the data
  always_ff @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      valid_pipe <= '0;
      mark_pipe  <= '0;
      sum_valid  <= 1'b0;
      sym_mark   <= 1'b0;
    end else begin
      valid_pipe <= {valid_pipe[2:0], chip_valid};
      mark_pipe  <= {mark_pipe[2:0], symbol_trig};
      sum_valid  <= valid_pipe[3];
      sym_mark   <= mark_pipe[3];
    end
  end

  // register the raw samples, masking happens in the first tree level
  always_ff @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      for (int i = 0; i < rx_correlator_pkg::N_SAMPLES; i++) begin
        samp_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < rx_correlator_pkg::N_SAMPLES; i++) begin
        samp_q[i] <= samples[i*rx_correlator_pkg::SAMPLE_W +: rx_correlator_pkg::SAMPLE_W];
      end
    end
  end

  // sign-extended sum of each group of four
  always_comb begin
    for (int g = 0; g < rx_correlator_pkg::N_GROUPS; g++) begin
      grp_sum[g] = '0;
      for (int k = 0; k < rx_correlator_pkg::GROUP_SIZE; k++) begin
        grp_sum[g] = grp_sum[g] + rx_correlator_pkg::chip_sum_t'(
                       samp_q[rx_correlator_pkg::GROUP_SIZE*g + k]);
      end
    end
  end

  // tree levels 5 -> 3 -> 2 -> 1, one register each
  always_ff @(posedge crx_clk) begin
    if (rrx_rst || !en) begin
      for (int g = 0; g < rx_correlator_pkg::N_GROUPS; g++) begin
        part1[g] <= '0;
      end
      part2[0] <= '0;
      part2[1] <= '0;
      part2[2] <= '0;
      part3[0] <= '0;
      part3[1] <= '0;
      chip_sum <= '0;
    end else begin
      for (int g = 0; g < rx_correlator_pkg::N_GROUPS; g++) begin
        part1[g] <= valid_pipe[0] ? grp_sum[g] : '0;  // idle chips count as zero
      end
      part2[0] <= part1[0] + part1[1];
      part2[1] <= part1[2] + part1[3];
      part2[2] <= part1[4];                        // odd one out, just delayed
      part3[0] <= part2[0] + part2[1];
      part3[1] <= part2[2];
      chip_sum <= part3[0] + part3[1];
    end
  end

endmodule

`default_nettype wire

// ==== logic/rx_correlator_pkg.sv ====
/* rx correlator shared definitions
   sample, chip sum and correlation widths, sequence LFSR constants and vector types */
`default_nettype none

package rx_correlator_pkg;

  // receive side
  localparam int SAMPLE_W   = 16;  // one ADC sample
  localparam int N_SAMPLES  = 20;  // samples per chip
  localparam int GROUP_SIZE = 4;   // samples added per first-level partial sum
  localparam int N_GROUPS   = N_SAMPLES / GROUP_SIZE;

  // correlation side
  localparam int N_SEQ      = 16;  // candidate sequences, also LFSR length
  localparam int CHIP_SUM_W = 21;  // holds 20 x full-scale sample
  localparam int CORR_W     = 41;

  // sample and sum types
  typedef logic signed [SAMPLE_W-1:0]      sample_t;
  typedef logic [N_SAMPLES*SAMPLE_W-1:0]   sample_bus_t;  // sample 0 in low bits
  typedef logic signed [CHIP_SUM_W-1:0]    chip_sum_t;
  typedef logic signed [CORR_W-1:0]        corr_t;
  typedef logic [N_SEQ*CORR_W-1:0]         corr_bus_t;    // sequence 0 in low bits

  // one sign per sequence, 1 adds and 0 subtracts
  typedef logic [N_SEQ-1:0]                seq_bits_t;

  // x^16 + x^14 + x^13 + x^11 + 1, taps on bits 15, 13, 12, 10
  // new bit 0 is the xor of the tapped bits, shift is toward bit 15
  localparam seq_bits_t SEQ_TAPS = 16'hB400;

  // loaded at every symbol start
  localparam seq_bits_t SEQ_SEED = 16'hACE1;

endpackage

`default_nettype wire
